//--- hdl/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// Accumulator width, small so saturation is reachable
`define CORR_ACC_W      8
`define CORR_NUM_ANT    24
`define CORR_NUM_PAIRS  12

// Pair tables, entry k in bits [10k+9:10k]
// Each entry is {antenna b, antenna a}, entry 11 first
// Block A correlates neighbours (2k, 2k+1)
`define CORR_PAIRS_A { \
   5'd23, 5'd22, 5'd21, 5'd20, 5'd19, 5'd18, 5'd17, 5'd16, \
   5'd15, 5'd14, 5'd13, 5'd12, 5'd11, 5'd10, 5'd9,  5'd8,  \
   5'd7,  5'd6,  5'd5,  5'd4,  5'd3,  5'd2,  5'd1,  5'd0 }

// Block B correlates across the halves (k, k+12)
`define CORR_PAIRS_B { \
   5'd23, 5'd11, 5'd22, 5'd10, 5'd21, 5'd9,  5'd20, 5'd8,  \
   5'd19, 5'd7,  5'd18, 5'd6,  5'd17, 5'd5,  5'd16, 5'd4,  \
   5'd15, 5'd3,  5'd14, 5'd2,  5'd13, 5'd1,  5'd12, 5'd0 }

`endif

//--- hdl/corr_pkg.sv
`include "corr_defs.svh"

package corr_pkg;

   // --------------------------------------------------
   // Shared vector types
   // --------------------------------------------------

   // Signed accumulator value, two's complement
   typedef logic signed [`CORR_ACC_W-1:0] acc_t;

   // One sample bit per antenna
   typedef logic [`CORR_NUM_ANT-1:0] ant_word_t;

   // Pair number, 0 to 11
   typedef logic [3:0] pair_idx_t;

   // Bus address
   // Bit 5 block select, bit 4 sine/cosine, bits 3..0 pair
   typedef logic [5:0] bus_adr_t;

endpackage

//--- hdl/cos_sin_mac.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module cos_sin_mac
   import corr_pkg::*;
#(
   parameter int ACC_W = `CORR_ACC_W
) (
   input  logic clk_x,
   input  logic rst,
   input  logic en_i,
   input  logic ar_i,
   input  logic br_i,
   input  logic bi_i,
   input  acc_t dcos_i,
   input  acc_t dsin_i,
   output logic valid_o,
   output acc_t qcos_o,
   output acc_t qsin_o,
   output logic oc_o,
   output logic os_o
);

   // Signed limits of the accumulator
   localparam acc_t ACC_MAX = acc_t'((1 << (ACC_W - 1)) - 1);
   localparam acc_t ACC_MIN = acc_t'(-(1 << (ACC_W - 1)));

   logic cos_up;
   logic sin_up;
   logic cos_sat;
   logic sin_sat;
   acc_t cos_next;
   acc_t sin_next;

   // One +/-1 step with saturation
   // Returns {saturated, next value}
   function automatic logic [ACC_W:0] step_acc(input acc_t acc, input logic up);
      logic sat;
      acc_t nxt;
      sat = up ? (acc == ACC_MAX) : (acc == ACC_MIN);
      if (sat) begin
         nxt = acc;
      end else if (up) begin
         nxt = acc + acc_t'(1);
      end else begin
         nxt = acc - acc_t'(1);
      end
      return {sat, nxt};
   endfunction

   // 1-bit products, equal bits count as +1
   assign cos_up = ar_i ~^ br_i;
   assign sin_up = ar_i ~^ bi_i;

   assign {cos_sat, cos_next} = step_acc(dcos_i, cos_up);
   assign {sin_sat, sin_next} = step_acc(dsin_i, sin_up);

   // Control outputs, one cycle after en_i
   always_ff @(posedge clk_x) begin
      if (rst) begin
         valid_o <= 1'b0;
         oc_o    <= 1'b0;
         os_o    <= 1'b0;
      end else begin
         valid_o <= en_i;
         // Pulse only on a real step that hit a limit
         oc_o    <= en_i & cos_sat;
         os_o    <= en_i & sin_sat;
      end
   end

   // Accumulator results
   always_ff @(posedge clk_x) begin
      if (en_i) begin
         qcos_o <= cos_next;
         qsin_o <= sin_next;
      end
   end

endmodule

//--- hdl/correlator.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module correlator
   import corr_pkg::*;
#(
   parameter int ACC_W = `CORR_ACC_W,
   parameter logic [10*`CORR_NUM_PAIRS-1:0] PAIRS = `CORR_PAIRS_A
) (
   input  logic       clk_x,
   input  logic       rst,
   input  logic       en_i,
   input  logic       sw_i,
   input  ant_word_t  re_i,
   input  ant_word_t  im_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  logic [4:0] adr_i,
   output logic       ack_o,
   output acc_t       dat_o,
   output logic       overflow_cos_o,
   output logic       overflow_sin_o
);

   localparam pair_idx_t PAIR_LAST = pair_idx_t'(`CORR_NUM_PAIRS - 1);

   // Pair sequencer
   pair_idx_t pair_q;
   logic      pair_wrap;

   // Bank control
   logic bank_q;
   logic swap_q;
   logic clear_q;

   // Pair table lookup
   logic [9:0] pair_entry;
   logic [4:0] ant_a;
   logic [4:0] ant_b;

   // Pipeline, read stage
   logic       go_q;
   logic       ar_q;
   logic       br_q;
   logic       bi_q;
   acc_t       dcos_q;
   acc_t       dsin_q;
   logic [4:0] wt_adr_q;

   // Pipeline, MAC and write stage
   logic       valid;
   logic       oc;
   logic       os;
   acc_t       qcos;
   acc_t       qsin;
   logic [4:0] wr_adr_q;

   // Accumulator RAMs, address {bank, pair}
   logic signed [ACC_W-1:0] cos_ram [32];
   logic signed [ACC_W-1:0] sin_ram [32];

   // Bus read address, always the inactive bank
   logic [4:0] rd_adr;

   // --------------------------------------------------
   // Pair sequencer
   // --------------------------------------------------
   assign pair_wrap = (pair_q == PAIR_LAST);

   always_ff @(posedge clk_x) begin
      if (rst) begin
         pair_q <= '0;
      end else if (en_i) begin
         pair_q <= pair_wrap ? '0 : pair_q + pair_idx_t'(1);
      end
   end

   // --------------------------------------------------
   // Bank switch and clear
   // --------------------------------------------------
   // Switch is armed by sw_i and taken on the next en_i at pair 11
   always_ff @(posedge clk_x) begin
      if (rst) begin
         bank_q  <= 1'b0;
         swap_q  <= 1'b0;
         clear_q <= 1'b1;
      end else if (en_i && pair_wrap && swap_q) begin
         bank_q  <= ~bank_q;
         swap_q  <= 1'b0;
         clear_q <= 1'b1;
      end else begin
         if (sw_i) begin
            swap_q <= 1'b1;
         end
         // One full pass done, new bank is zeroed
         if (en_i && pair_wrap) begin
            clear_q <= 1'b0;
         end
      end
   end

   // --------------------------------------------------
   // Pair table and antenna select
   // --------------------------------------------------
   assign pair_entry = PAIRS[pair_q*10 +: 10];
   assign ant_a      = pair_entry[4:0];
   assign ant_b      = pair_entry[9:5];

   // --------------------------------------------------
   // Read stage
   // --------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         go_q <= 1'b0;
      end else begin
         go_q <= en_i;
      end
   end

   always_ff @(posedge clk_x) begin
      if (en_i) begin
         // Zero input while clearing
         dcos_q   <= clear_q ? '0 : cos_ram[{bank_q, pair_q}];
         dsin_q   <= clear_q ? '0 : sin_ram[{bank_q, pair_q}];
         ar_q     <= re_i[ant_a];
         br_q     <= re_i[ant_b];
         bi_q     <= im_i[ant_b];
         wt_adr_q <= {bank_q, pair_q};
      end
      // Address follows the sample into the MAC
      if (go_q) begin
         wr_adr_q <= wt_adr_q;
      end
   end

   // --------------------------------------------------
   // MAC and write-back
   // --------------------------------------------------
   cos_sin_mac #(
      .ACC_W   (ACC_W)
   ) mac_i (
      .clk_x   (clk_x),
      .rst     (rst),
      .en_i    (go_q),
      .ar_i    (ar_q),
      .br_i    (br_q),
      .bi_i    (bi_q),
      .dcos_i  (dcos_q),
      .dsin_i  (dsin_q),
      .valid_o (valid),
      .qcos_o  (qcos),
      .qsin_o  (qsin),
      .oc_o    (oc),
      .os_o    (os)
   );

   // Write two cycles after en_i
   always_ff @(posedge clk_x) begin
      if (valid) begin
         cos_ram[wr_adr_q] <= qcos;
         sin_ram[wr_adr_q] <= qsin;
      end
   end

   // Overflow pulses made sticky
   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else begin
         if (oc) begin
            overflow_cos_o <= 1'b1;
         end
         if (os) begin
            overflow_sin_o <= 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // Bus read port
   // --------------------------------------------------
   assign rd_adr = {~bank_q, adr_i[3:0]};

   // Every strobe is acked, one cycle later
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= cyc_i & stb_i;
      end
   end

   always_ff @(posedge clk_x) begin
      if (cyc_i && stb_i) begin
         // Bit 4 picks sine over cosine
         dat_o <= adr_i[4] ? sin_ram[rd_adr] : cos_ram[rd_adr];
      end
   end

endmodule

//--- hdl/correlator_array.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module correlator_array
   import corr_pkg::*;
(
   input  logic       clk_x,
   input  logic       rst,
   input  logic       en_i,
   input  logic       sw_i,
   input  ant_word_t  re_i,
   input  ant_word_t  im_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  bus_adr_t   adr_i,
   output logic       ack_o,
   output acc_t       dat_o,
   output logic [1:0] overflow_o
);

   // Per-block bus and flag signals, index is the block
   logic [1:0] blk_cyc;
   logic [1:0] blk_stb;
   logic [1:0] blk_ack;
   logic [1:0] blk_oc;
   logic [1:0] blk_os;
   acc_t       blk_dat [2];

   // Block select held for the read data
   logic sel_q;

   // --------------------------------------------------
   // Block select
   // --------------------------------------------------
   assign blk_cyc = {cyc_i & adr_i[5], cyc_i & ~adr_i[5]};
   assign blk_stb = {stb_i & adr_i[5], stb_i & ~adr_i[5]};

   always_ff @(posedge clk_x) begin
      if (cyc_i && stb_i) begin
         sel_q <= adr_i[5];
      end
   end

   // --------------------------------------------------
   // Correlator blocks
   // --------------------------------------------------
   // Same antennas, different pair tables
   correlator #(
      .ACC_W          (`CORR_ACC_W),
      .PAIRS          (`CORR_PAIRS_A)
   ) corr_a_i (
      .clk_x          (clk_x),
      .rst            (rst),
      .en_i           (en_i),
      .sw_i           (sw_i),
      .re_i           (re_i),
      .im_i           (im_i),
      .cyc_i          (blk_cyc[0]),
      .stb_i          (blk_stb[0]),
      .adr_i          (adr_i[4:0]),
      .ack_o          (blk_ack[0]),
      .dat_o          (blk_dat[0]),
      .overflow_cos_o (blk_oc[0]),
      .overflow_sin_o (blk_os[0])
   );

   correlator #(
      .ACC_W          (`CORR_ACC_W),
      .PAIRS          (`CORR_PAIRS_B)
   ) corr_b_i (
      .clk_x          (clk_x),
      .rst            (rst),
      .en_i           (en_i),
      .sw_i           (sw_i),
      .re_i           (re_i),
      .im_i           (im_i),
      .cyc_i          (blk_cyc[1]),
      .stb_i          (blk_stb[1]),
      .adr_i          (adr_i[4:0]),
      .ack_o          (blk_ack[1]),
      .dat_o          (blk_dat[1]),
      .overflow_cos_o (blk_oc[1]),
      .overflow_sin_o (blk_os[1])
   );

   // --------------------------------------------------
   // Read data and flags
   // --------------------------------------------------
   assign dat_o = sel_q ? blk_dat[1] : blk_dat[0];
   assign ack_o = |blk_ack;

   // Bit 0 cosine, bit 1 sine
   assign overflow_o = {|blk_os, |blk_oc};

endmodule

//--- dv/correlator_checker.sv
`timescale 1ns/1ns

module correlator_checker (
   input logic       clk_x,
   input logic       rst,
   input logic       cyc_i,
   input logic       stb_i,
   input logic       ack_i,
   input logic [1:0] overflow_i
);

   // --------------------------------------------------
   // Bus handshake
   // --------------------------------------------------
   // Strobe answered on the next edge
   ack_follows_strobe: assert property (
      @(posedge clk_x) disable iff (rst)
      (cyc_i && stb_i) |=> ack_i
   ) else $error("ack missing one cycle after strobe");

   // No spurious ack
   ack_has_strobe: assert property (
      @(posedge clk_x) disable iff (rst)
      ack_i |-> $past(cyc_i && stb_i)
   ) else $error("ack without a preceding strobe");

   // --------------------------------------------------
   // Overflow flags
   // --------------------------------------------------
   // Sticky until reset
   overflow_cos_sticky: assert property (
      @(posedge clk_x) disable iff (rst)
      overflow_i[0] |=> overflow_i[0]
   ) else $error("cosine overflow flag dropped");

   overflow_sin_sticky: assert property (
      @(posedge clk_x) disable iff (rst)
      overflow_i[1] |=> overflow_i[1]
   ) else $error("sine overflow flag dropped");

   // Cleared by reset
   overflow_reset: assert property (
      @(posedge clk_x)
      rst |=> (overflow_i == 2'b00)
   ) else $error("overflow flags set after reset");

endmodule

//--- dv/correlator_tb.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module correlator_tb
   import corr_pkg::*;
;

   localparam int OP_RUN = 0;
   localparam int OP_SW  = 1;
   localparam int OP_RD  = 2;
   localparam int OP_AK  = 3;
   localparam int OP_OV  = 4;

   logic       clk_x;
   logic       rst;
   logic       en_i;
   logic       sw_i;
   ant_word_t  re_i;
   ant_word_t  im_i;
   logic       cyc_i;
   logic       stb_i;
   bus_adr_t   adr_i;
   logic       ack_o;
   acc_t       dat_o;
   logic [1:0] overflow_o;

   // Parsed trace with one entry per command
   int          op_q [$];
   int          n_q [$];
   logic [23:0] a_q [$];
   logic [23:0] b_q [$];

   int          pair_pos;
   int          run_total;
   longint      cycle_cnt;
   longint      cycle_limit;

   correlator_array dut_i (
      .clk_x      (clk_x),
      .rst        (rst),
      .en_i       (en_i),
      .sw_i       (sw_i),
      .re_i       (re_i),
      .im_i       (im_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .adr_i      (adr_i),
      .ack_o      (ack_o),
      .dat_o      (dat_o),
      .overflow_o (overflow_o)
   );

   bind correlator_array correlator_checker checker_i (
      .clk_x      (clk_x),
      .rst        (rst),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .ack_i      (ack_o),
      .overflow_i (overflow_o)
   );

   // --------------------------------------------------
   // Clock and timeout
   // --------------------------------------------------
   initial begin
      clk_x = 1'b0;
      forever #4 clk_x = ~clk_x;
   end

   always @(posedge clk_x) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $fatal(1, "simulation stopped on timeout");
      end
   end

   // --------------------------------------------------
   // Helper tasks
   // --------------------------------------------------
   task automatic stop_on_error();
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   // Inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk_x);
      #1;
   endtask

   task automatic check_acc(input string name, input bus_adr_t adr, input acc_t got,
                            input acc_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s adr=%h got=%h expected=%h", name, adr, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got=%h expected=%h", name, got, exp);
         stop_on_error();
      end
   endtask

   // Strobe one cycle and wait for ack with a bound
   task automatic bus_strobe(input bus_adr_t adr);
      int waited;
      waited = 0;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = adr;
      tick();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      while (!ack_o && waited < 4) begin
         tick();
         waited = waited + 1;
      end
      if (!ack_o) begin
         $display("No acknowledge came back for the read at address %h", adr);
         stop_on_error();
      end
      tick();
   endtask

   task automatic bus_read(input bus_adr_t adr, input acc_t exp);
      int waited;
      waited = 0;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = adr;
      tick();
      cyc_i = 1'b0;
      stb_i = 1'b0;
      while (!ack_o && waited < 4) begin
         tick();
         waited = waited + 1;
      end
      if (!ack_o) begin
         $display("No acknowledge came back for the read at address %h", adr);
         stop_on_error();
      end
      check_acc("dat_o", adr, dat_o, exp);
      tick();
   endtask

   // Samples held with an idle gap now and then
   task automatic run_samples(input int n, input ant_word_t re, input ant_word_t im);
      re_i = re;
      im_i = im;
      for (int i = 0; i < n; i++) begin
         if ($urandom % 16 == 0) begin
            en_i = 1'b0;
            tick();
         end
         en_i = 1'b1;
         tick();
         pair_pos = (pair_pos + 1) % `CORR_NUM_PAIRS;
      end
      en_i = 1'b0;
      // Let the write pipeline drain
      repeat (3) tick();
   endtask

   // Arm and step through the cycle on the last pair
   task automatic switch_bank();
      logic last;
      sw_i = 1'b1;
      tick();
      sw_i = 1'b0;
      do begin
         last = (pair_pos == `CORR_NUM_PAIRS - 1);
         en_i = 1'b1;
         tick();
         pair_pos = (pair_pos + 1) % `CORR_NUM_PAIRS;
      end while (!last);
      en_i = 1'b0;
      repeat (3) tick();
   endtask

   task automatic load_trace();
      int          fd;
      int          cnt;
      string       line;
      string       op;
      int          n;
      logic [23:0] a;
      logic [23:0] b;
      fd = $fopen("dv/correlator_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file dv/correlator_trace.txt");
         stop_on_error();
      end
      while (!$feof(fd)) begin
         line = "";
         n = 0;
         a = '0;
         b = '0;
         cnt = $fgets(line, fd);
         if (cnt > 1 && line[0] != "#") begin
            cnt = $sscanf(line, "%s", op);
            case (op)
               "RUN": begin
                  cnt = $sscanf(line, "%s %d %h %h", op, n, a, b);
                  op_q.push_back(OP_RUN);
                  run_total = run_total + n;
               end
               "SW": op_q.push_back(OP_SW);
               "RD": begin
                  cnt = $sscanf(line, "%s %h %h", op, a, b);
                  op_q.push_back(OP_RD);
               end
               "AK": begin
                  cnt = $sscanf(line, "%s %h", op, a);
                  op_q.push_back(OP_AK);
               end
               "OV": begin
                  cnt = $sscanf(line, "%s %h", op, b);
                  op_q.push_back(OP_OV);
               end
               default: begin
                  $display("Unknown command in the trace file: %s", line);
                  stop_on_error();
               end
            endcase
            n_q.push_back(n);
            a_q.push_back(a);
            b_q.push_back(b);
         end
      end
      $fclose(fd);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      rst         = 1'b1;
      en_i        = 1'b0;
      sw_i        = 1'b0;
      re_i        = '0;
      im_i        = '0;
      cyc_i       = 1'b0;
      stb_i       = 1'b0;
      adr_i       = '0;
      pair_pos    = 0;
      run_total   = 0;
      cycle_cnt   = 0;
      cycle_limit = 64'd1000000;
      void'($urandom(44));

      load_trace();
      cycle_limit = run_total + 50 * op_q.size() + 20;

      repeat (10) @(posedge clk_x);
      #1;
      rst = 1'b0;
      tick();

      foreach (op_q[i]) begin
         case (op_q[i])
            OP_RUN: run_samples(n_q[i], a_q[i], b_q[i]);
            OP_SW:  switch_bank();
            OP_RD:  bus_read(bus_adr_t'(a_q[i]), acc_t'(b_q[i]));
            OP_AK:  bus_strobe(bus_adr_t'(a_q[i]));
            OP_OV:  check_flag("overflow_o", overflow_o, b_q[i][1:0]);
            default: ;
         endcase
      end

      // Any failed check has already stopped the run
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- dv/correlator_trace.txt
# Commands: RUN n re im | SW | RD adr expected | AK adr | OV expected
# All values hex except n; adr bit 5 block, bit 4 sine, bits 3..0 pair
OV 0
# Equal bits everywhere, 24 samples
RUN 23 000000 000000
SW
RD 00 02
RD 05 02
RD 0b 02
RD 10 02
RD 1b 02
RD 20 02
RD 27 02
RD 30 02
RD 3b 02
# Antenna 1 opposite, hits pair 0 of A and pair 1 of B
RUN 23 000002 000000
SW
RD 00 fe
RD 10 02
RD 01 02
RD 11 02
RD 20 02
RD 21 fe
RD 31 fe
RD 32 02
RD 2b 02
# Reused bank, older values still read mid-run
RUN 12 ffffff 000000
RD 00 fe
RD 21 fe
RD 31 fe
RD 05 02
RUN 11 ffffff 000000
SW
RD 00 02
RD 10 fe
RD 21 02
RD 31 fe
RD 3b fe
OV 0
# Long constant run, 129 samples per pair
RUN 1547 000000 000000
SW
RD 00 7f
RD 1b 7f
RD 26 7f
RD 3b 7f
OV 3
# Unused pair addresses still acked
AK 0c
AK 3f
OV 3

//--- project.f
+incdir+hdl
hdl/corr_pkg.sv
hdl/cos_sin_mac.sv
hdl/correlator.sv
hdl/correlator_array.sv
dv/correlator_checker.sv
dv/correlator_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f \
   --top-module correlator_tb \
   -Mdir obj_dir \
   -o correlator_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Build failed with status $status"
   exit 1
fi

./obj_dir/correlator_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
   echo "Run passed"
   exit 0
else
   echo "Run failed, pass message not found in $LOG"
   exit 1
fi
